// File: all.f
+incdir+src
src/lsu_pkg.sv
src/insn_decode.sv
src/addr_execute.sv
src/byte_memory.sv
src/load_result.sv
src/lsu_top.sv
dv/lsu_asserts.sv
dv/lsu_tb.sv

// File: dv/lsu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts import lsu_pkg::*; (
  input logic  clk,
  input logic  reset,
  input logic  insn_valid,
  input logic  insn_ready,
  input insn_u insn,
  input logic  mem_req_valid,
  input logic  mem_done,
  input logic  wb_valid
);

  int   stable_fails = 0;
  int   req_fails = 0;
  int   reset_fails = 0;
  logic mem_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_busy <= 1'b0;
    end else if (mem_req_valid) begin
      mem_busy <= 1'b1;  // request out until mem_done.
    end else if (mem_done) begin
      mem_busy <= 1'b0;
    end
  end

  insn_hold: assert property (@(posedge clk) disable iff (reset)
    (insn_valid && !insn_ready) |=> (insn_valid && $stable(insn)))
    else begin
      stable_fails++;
      $error("insn changed or valid dropped while stalled");
    end

  one_request: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid |-> !mem_busy)
    else begin
      req_fails++;
      $error("second memory request issued before mem_done");
    end

  wb_after_reset: assert property (@(posedge clk)
    reset |=> !wb_valid)
    else begin
      reset_fails++;
      $error("wb_valid high in the cycle after reset");
    end

endmodule

bind lsu_top lsu_asserts u_lsu_asserts (
  .clk           (clk),
  .reset         (reset),
  .insn_valid    (insn_valid),
  .insn_ready    (insn_ready),
  .insn          (insn),
  .mem_req_valid (mem_req_valid),
  .mem_done      (mem_done),
  .wb_valid      (wb_valid)
);

`default_nettype wire

// File: dv/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

  localparam int clk_period = 4;
  localparam int num_insn = 225;  // directed plus random.

  logic  clk;
  logic  reset;
  logic  insn_valid;
  logic  insn_ready;
  insn_u insn;
  logic  wb_valid;
  wb_t   wb;

  integer      seed;
  logic [15:0] regs_model [0:7];
  logic [7:0]  mem_model [logic [15:0]];  // untouched bytes read as zero.
  wb_t         exp_wb [0:511];
  string       exp_name [0:511];
  string       test_name;
  int          n_exp = 0;
  int          n_got = 0;
  int          check_errors = 0;
  int          end_errors = 0;

  lsu_top u_lsu_top (
    .clk        (clk),
    .reset      (reset),
    .insn_valid (insn_valid),
    .insn_ready (insn_ready),
    .insn       (insn),
    .wb_valid   (wb_valid),
    .wb         (wb)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic insn_u mem_insn(input opcode_t op, input logic [2:0] rd,
                                     input logic [2:0] rs, input logic [6:0] offset);
    insn_u w;
    w.mem.opcode = op;
    w.mem.rd     = rd;
    w.mem.rs     = rs;
    w.mem.offset = offset;
    return w;
  endfunction

  function automatic insn_u imm_insn(input logic [2:0] rd, input logic [9:0] imm);
    insn_u w;
    w.imm.opcode = op_li;
    w.imm.rd     = rd;
    w.imm.imm    = imm;
    return w;
  endfunction

  function automatic logic [7:0] model_byte(input logic [15:0] a);
    return mem_model.exists(a) ? mem_model[a] : 8'h00;
  endfunction

  // runs one instruction on the model and queues its writeback.
  task automatic model_step(input insn_u w);
    logic [15:0] addr;
    logic [15:0] addr_hi;
    logic [15:0] data;
    logic        has_wb;
    addr    = regs_model[w.mem.rs] + {{9{w.mem.offset[6]}}, w.mem.offset};
    addr_hi = addr + 16'd1;  // little-endian high byte wraps too.
    has_wb  = 1'b1;
    data    = 16'h0000;
    case (w.mem.opcode)
      op_li: data = {6'd0, w.imm.imm};
      op_lb: data = {8'h00, model_byte(addr)};
      op_lw: data = {model_byte(addr_hi), model_byte(addr)};
      op_sb: begin
        mem_model[addr] = regs_model[w.mem.rd][7:0];
        has_wb = 1'b0;
      end
      op_sw: begin
        mem_model[addr]    = regs_model[w.mem.rd][7:0];
        mem_model[addr_hi] = regs_model[w.mem.rd][15:8];
        has_wb = 1'b0;
      end
      default: has_wb = 1'b0;  // no-op.
    endcase
    if (has_wb) begin
      regs_model[w.mem.rd] = data;
      exp_wb[n_exp].rd     = w.mem.rd;
      exp_wb[n_exp].data   = data;
      exp_name[n_exp]      = test_name;
      n_exp++;
    end
  endtask

  // called 1 ns after an edge; returns 1 ns after the accepting edge.
  task automatic send(input insn_u w);
    logic took;
    model_step(w);
    insn_valid = 1'b1;
    insn       = w;
    took       = 1'b0;
    while (!took) begin
      took = insn_ready;
      @(posedge clk);
      #1;
    end
    insn_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      assert (n_got < n_exp) else begin
        check_errors++;
        $display("Extra writeback to r%0d with data %h, none was expected", wb.rd, wb.data);
      end
      if (n_got < n_exp) begin
        assert (wb == exp_wb[n_got]) else begin
          check_errors++;
          $display("Mismatch %s: expected %h, actual %h", exp_name[n_got], exp_wb[n_got], wb);
        end
        n_got++;
      end
    end
  end

  initial begin
    #(10 * num_insn * 8 * clk_period);
    $display("Timeout: run did not finish within %0d cycles", 10 * num_insn * 8);
    $display("Test failed");
    $finish;
  end

  initial begin
    int          guard;
    int          total;
    logic [31:0] r;
    insn_u       w;
    seed       = 32'h20ec3656;
    reset      = 1'b1;
    insn_valid = 1'b0;
    insn       = '0;
    test_name  = "reset";
    for (int i = 0; i < 8; i++) begin
      regs_model[i] = 16'h0000;
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    test_name = "li";
    send(imm_insn(3'd1, 10'h3ff));
    send(imm_insn(3'd2, 10'h155));
    send(imm_insn(3'd0, 10'h100));

    test_name = "sw_lw";
    send(imm_insn(3'd1, 10'h200));
    send(imm_insn(3'd2, 10'h3a5));
    send(mem_insn(op_sw, 3'd2, 3'd1, 7'd4));
    send(mem_insn(op_lw, 3'd3, 3'd1, 7'd4));
    send(mem_insn(op_lw, 3'd4, 3'd1, 7'd8));  // untouched.

    test_name = "bytes";
    send(mem_insn(op_lb, 3'd5, 3'd1, 7'd4));
    send(mem_insn(op_lb, 3'd6, 3'd1, 7'd5));
    send(imm_insn(3'd7, 10'h0ee));
    send(mem_insn(op_sb, 3'd7, 3'd1, 7'd5));
    send(mem_insn(op_lw, 3'd3, 3'd1, 7'd4));

    test_name = "wrap";
    send(imm_insn(3'd0, 10'h000));
    send(mem_insn(op_sw, 3'd2, 3'd0, 7'h7f));  // word at ffff.
    send(mem_insn(op_lw, 3'd3, 3'd0, 7'h7f));
    send(mem_insn(op_lb, 3'd4, 3'd0, 7'd0));
    send(mem_insn(op_lb, 3'd5, 3'd0, 7'h7f));
    send(imm_insn(3'd6, 10'h0ff));
    send(mem_insn(op_sb, 3'd6, 3'd0, 7'd16));
    send(mem_insn(op_sb, 3'd6, 3'd0, 7'd17));
    send(mem_insn(op_lw, 3'd6, 3'd0, 7'd16));  // r6 becomes ffff.
    send(mem_insn(op_lw, 3'd3, 3'd6, 7'd1));
    send(mem_insn(op_sw, 3'd7, 3'd6, 7'd3));
    send(mem_insn(op_lw, 3'd4, 3'd0, 7'd2));

    test_name = "random";
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      if (r[2:0] == 3'd0) begin
        w = imm_insn(r[5:3], r[15:6]);
      end else begin
        w = mem_insn(opcode_t'(r[2:0]), r[5:3], r[8:6], r[15:9]);
      end
      send(w);
      if (r[16]) begin
        idle(int'(r[18:17]));
      end
    end

    guard = 0;
    while (n_got < n_exp && guard < 200) begin
      @(posedge clk);
      guard++;
    end
    idle(20);
    assert (n_got == n_exp) else begin
      end_errors++;
      $display("Missing writebacks: %0d expected, %0d seen", n_exp, n_got);
    end

    total = check_errors + end_errors + u_lsu_top.u_lsu_asserts.stable_fails +
            u_lsu_top.u_lsu_asserts.req_fails + u_lsu_top.u_lsu_asserts.reset_fails;
    $display("errors: %0d total, %0d writeback checks, %0d end of run, %0d writebacks seen",
             total, check_errors, end_errors, n_got);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module lsu_tb -o lsu_sim

# a failed assertion may end the run with a nonzero status, so the log decides.
./obj_dir/lsu_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test completed successfully$" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: src/addr_execute.sv
`timescale 1ns/1ps
`default_nettype none

module addr_execute import lsu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        dec_valid,
  output logic        dec_ready,
  input  dec_t        dec,
  output logic [2:0]  rd_addr_a,
  output logic [2:0]  rd_addr_b,
  input  logic [15:0] rd_data_a,
  input  logic [15:0] rd_data_b,
  output logic        mem_req_valid,
  output mem_req_t    mem_req,
  input  logic        mem_done,
  output logic        pend_valid,
  output wb_t         pend_wb,
  output logic [2:0]  load_rd,
  output bus_size_t   load_size,
  output logic        load_valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait
  } state_t;

  state_t state;
  dec_t   cur;
  logic   is_load;
  logic   is_store;
  logic   dec_real;

  assign is_load  = (cur.op == op_lb) || (cur.op == op_lw);
  assign is_store = (cur.op == op_sb) || (cur.op == op_sw);
  assign dec_real = (dec.op == op_li) || (dec.op == op_lb) || (dec.op == op_lw) ||
                    (dec.op == op_sb) || (dec.op == op_sw);

  assign dec_ready = (state == st_idle);
  assign rd_addr_a = cur.rs;  // base.
  assign rd_addr_b = cur.rd;  // store data.

  assign mem_req_valid = (state == st_issue) && (is_load || is_store);

  always_comb begin
    if (is_store) begin
      mem_req.op = bus_op_write;
    end else if (is_load) begin
      mem_req.op = bus_op_read;
    end else begin
      mem_req.op = bus_op_idle;
    end
    mem_req.size  = ((cur.op == op_lw) || (cur.op == op_sw)) ? bus_size_word : bus_size_byte;
    mem_req.addr  = rd_data_a + cur.value;  // wraps at 16 bits.
    mem_req.wdata = rd_data_b;
  end

  assign pend_valid   = (state == st_issue) && (cur.op == op_li);
  assign pend_wb.rd   = cur.rd;
  assign pend_wb.data = cur.value;

  assign load_rd    = cur.rd;
  assign load_size  = mem_req.size;
  assign load_valid = (state == st_wait) && is_load;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      unique case (state)
        st_idle: begin
          if (dec_valid && dec_real) begin
            state <= st_issue;
          end
        end
        st_issue: begin
          state <= (cur.op == op_li) ? st_idle : st_wait;
        end
        st_wait: begin
          if (mem_done) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && dec_valid) begin
      cur <= dec;
    end
  end

endmodule

`default_nettype wire

// File: src/byte_memory.sv
`timescale 1ns/1ps
`include "lsu_config.svh"
`default_nettype none

module byte_memory import lsu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        mem_req_valid,
  input  mem_req_t    mem_req,
  output logic        mem_done,
  output logic [15:0] mem_rdata
);

  typedef enum logic [2:0] {
    st_idle,
    st_read_low,
    st_read_high,
    st_write_low,
    st_write_high
  } state_t;

  logic [7:0]  mem [0:`LSU_MEM_BYTES-1];
  state_t      state;
  logic [15:0] addr_q;
  logic [15:0] addr_hi;
  logic [15:0] wdata_q;
  bus_size_t   size_q;

  initial begin
    for (int i = 0; i < `LSU_MEM_BYTES; i++) begin
      mem[i] = 8'h00;
    end
  end

  assign addr_hi = addr_q + 16'd1;  // high byte wraps to 0.

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      mem_done <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      unique case (state)
        st_idle: begin
          if (mem_req_valid && mem_req.op == bus_op_read) begin
            state <= st_read_low;
          end else if (mem_req_valid && mem_req.op == bus_op_write) begin
            state <= st_write_low;
          end
        end
        st_read_low: begin
          if (size_q == bus_size_word) begin
            state <= st_read_high;
          end else begin
            mem_done <= 1'b1;
            state    <= st_idle;
          end
        end
        st_write_low: begin
          if (size_q == bus_size_word) begin
            state <= st_write_high;
          end else begin
            mem_done <= 1'b1;
            state    <= st_idle;
          end
        end
        st_read_high, st_write_high: begin
          mem_done <= 1'b1;
          state    <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && mem_req_valid) begin
      addr_q  <= mem_req.addr;
      wdata_q <= mem_req.wdata;
      size_q  <= mem_req.size;
    end
    case (state)
      st_read_low:   mem_rdata <= {8'h00, mem[addr_q]};  // byte reads stop here.
      st_read_high:  mem_rdata <= {mem[addr_hi], mem_rdata[7:0]};
      st_write_low:  mem[addr_q] <= wdata_q[7:0];
      st_write_high: mem[addr_hi] <= wdata_q[15:8];
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: src/insn_decode.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decode import lsu_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  insn_valid,
  output logic  insn_ready,
  input  insn_u insn,
  output logic  dec_valid,
  input  logic  dec_ready,
  output dec_t  dec
);

  dec_t dec_next;

  // free slot, or the held item leaves on this edge.
  assign insn_ready = !dec_valid || dec_ready;

  always_comb begin
    dec_next.op = insn.mem.opcode;
    dec_next.rd = insn.mem.rd;
    if (insn.mem.opcode == op_li) begin
      dec_next.rs    = 3'd0;
      dec_next.value = {6'd0, insn.imm.imm};
    end else begin
      dec_next.rs    = insn.mem.rs;
      dec_next.value = {{9{insn.mem.offset[6]}}, insn.mem.offset};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else if (insn_ready) begin
      dec_valid <= insn_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (insn_valid && insn_ready) begin
      dec <= dec_next;
    end
  end

endmodule

`default_nettype wire

// File: src/load_result.sv
`timescale 1ns/1ps
`include "lsu_config.svh"
`default_nettype none

module load_result import lsu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        mem_done,
  input  logic [15:0] mem_rdata,
  input  logic [2:0]  load_rd,
  input  bus_size_t   load_size,
  input  logic        load_valid,
  input  logic        pend_valid,
  input  wb_t         pend_wb,
  input  logic [2:0]  rd_addr_a,
  input  logic [2:0]  rd_addr_b,
  output logic [15:0] rd_data_a,
  output logic [15:0] rd_data_b,
  output logic        wb_valid,
  output wb_t         wb
);

  logic [15:0] regs [0:`LSU_NUM_REGS-1];
  logic        wr_en;
  wb_t         wr;

  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

  // li and load never land on the same edge.
  always_comb begin
    wr_en = 1'b0;
    wr    = pend_wb;
    if (pend_valid) begin
      wr_en = 1'b1;
    end else if (mem_done && load_valid) begin
      wr_en   = 1'b1;
      wr.rd   = load_rd;
      wr.data = (load_size == bus_size_byte) ? {8'h00, mem_rdata[7:0]} : mem_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
      for (int i = 0; i < `LSU_NUM_REGS; i++) begin
        regs[i] <= 16'h0000;
      end
    end else begin
      wb_valid <= wr_en;
      if (wr_en) begin
        regs[wr.rd] <= wr.data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      wb <= wr;
    end
  end

endmodule

`default_nettype wire

// File: src/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

`default_nettype none

// architectural register count; sets the 3-bit register index.
`define LSU_NUM_REGS 8

// byte memory size covers the full 16-bit address space.
`define LSU_MEM_BYTES 65536

`default_nettype wire

`endif

// File: src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  typedef enum logic [2:0] {
    op_li    = 3'd0,
    op_lb    = 3'd1,
    op_lw    = 3'd2,
    op_sb    = 3'd3,
    op_sw    = 3'd4,
    op_nop_5 = 3'd5,  // unused codes run as no-ops.
    op_nop_6 = 3'd6,
    op_nop_7 = 3'd7
  } opcode_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [2:0]  rd;      // load target, or store data source.
    logic [2:0]  rs;      // base register.
    logic [6:0]  offset;  // signed.
  } insn_mem_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [2:0]  rd;
    logic [9:0]  imm;     // zero-extended.
  } insn_imm_t;

  // opcode sits in the same bits of both forms.
  typedef union packed {
    insn_mem_t mem;
    insn_imm_t imm;
  } insn_u;

  typedef enum logic [1:0] {
    bus_op_idle,
    bus_op_read,
    bus_op_write
  } bus_op_t;

  typedef enum logic {
    bus_size_byte,
    bus_size_word
  } bus_size_t;

  typedef struct packed {
    opcode_t     op;
    logic [2:0]  rd;
    logic [2:0]  rs;
    logic [15:0] value;   // offset or immediate after extension.
  } dec_t;

  typedef struct packed {
    bus_op_t     op;
    bus_size_t   size;
    logic [15:0] addr;
    logic [15:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [2:0]  rd;
    logic [15:0] data;
  } wb_t;

endpackage

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  insn_valid,
  output logic  insn_ready,
  input  insn_u insn,
  output logic  wb_valid,
  output wb_t   wb
);

  logic        dec_valid;
  logic        dec_ready;
  dec_t        dec;
  logic [2:0]  rd_addr_a;
  logic [2:0]  rd_addr_b;
  logic [15:0] rd_data_a;
  logic [15:0] rd_data_b;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_done;
  logic [15:0] mem_rdata;
  logic        pend_valid;
  wb_t         pend_wb;
  logic [2:0]  load_rd;
  bus_size_t   load_size;
  logic        load_valid;

  insn_decode u_insn_decode (
    .clk        (clk),
    .reset      (reset),
    .insn_valid (insn_valid),
    .insn_ready (insn_ready),
    .insn       (insn),
    .dec_valid  (dec_valid),
    .dec_ready  (dec_ready),
    .dec        (dec)
  );

  addr_execute u_addr_execute (
    .clk           (clk),
    .reset         (reset),
    .dec_valid     (dec_valid),
    .dec_ready     (dec_ready),
    .dec           (dec),
    .rd_addr_a     (rd_addr_a),
    .rd_addr_b     (rd_addr_b),
    .rd_data_a     (rd_data_a),
    .rd_data_b     (rd_data_b),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_done      (mem_done),
    .pend_valid    (pend_valid),
    .pend_wb       (pend_wb),
    .load_rd       (load_rd),
    .load_size     (load_size),
    .load_valid    (load_valid)
  );

  byte_memory u_byte_memory (
    .clk           (clk),
    .reset         (reset),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_done      (mem_done),
    .mem_rdata     (mem_rdata)
  );

  load_result u_load_result (
    .clk        (clk),
    .reset      (reset),
    .mem_done   (mem_done),
    .mem_rdata  (mem_rdata),
    .load_rd    (load_rd),
    .load_size  (load_size),
    .load_valid (load_valid),
    .pend_valid (pend_valid),
    .pend_wb    (pend_wb),
    .rd_addr_a  (rd_addr_a),
    .rd_addr_b  (rd_addr_b),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b),
    .wb_valid   (wb_valid),
    .wb         (wb)
  );

endmodule

`default_nettype wire
